//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = control_unit_tb
FILELIST  = control_unit.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- control_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module control_sequencer #(
    parameter int MEM_WAIT = 2,
    parameter int EXC_WAIT = 8
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire isa_pkg::instr_class_e instr_class,
    input  wire                        ov,
    output ctrl_pkg::state_e           state,
    output ctrl_pkg::exc_cause_e       cause
);

    localparam int CNT_MAX = (MEM_WAIT > EXC_WAIT) ? MEM_WAIT : EXC_WAIT;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    ctrl_pkg::state_e     next_state;
    ctrl_pkg::exc_cause_e next_cause;
    logic [CNT_W-1:0]     wait_cnt;
    logic                 in_wait;
    logic                 wait_done;

    assign in_wait = (state == ctrl_pkg::st_fetch_wait) || (state == ctrl_pkg::st_exc_wait);

    always_comb begin
        case (state)
            ctrl_pkg::st_fetch_wait: wait_done = (wait_cnt == CNT_W'(MEM_WAIT - 1));
            ctrl_pkg::st_exc_wait:   wait_done = (wait_cnt == CNT_W'(EXC_WAIT - 1));
            default:                 wait_done = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        next_cause = cause;
        case (state)
            ctrl_pkg::st_stack_init:  next_state = ctrl_pkg::st_fetch_wait;
            ctrl_pkg::st_fetch_wait: begin
                if (wait_done) begin
                    next_state = ctrl_pkg::st_fetch_latch;
                end
            end
            ctrl_pkg::st_fetch_latch: next_state = ctrl_pkg::st_decode_regs;
            ctrl_pkg::st_decode_regs: next_state = ctrl_pkg::st_dispatch;
            // Only place the decoder output is looked at
            ctrl_pkg::st_dispatch: begin
                case (instr_class)
                    isa_pkg::cls_add:   next_state = ctrl_pkg::st_alu_add;
                    isa_pkg::cls_and:   next_state = ctrl_pkg::st_alu_and;
                    isa_pkg::cls_sub:   next_state = ctrl_pkg::st_alu_sub;
                    isa_pkg::cls_addi:  next_state = ctrl_pkg::st_alu_imm_trap;
                    isa_pkg::cls_addiu: next_state = ctrl_pkg::st_alu_imm_wrap;
                    default: begin
                        next_state = ctrl_pkg::st_exc_wait;
                        next_cause = ctrl_pkg::cause_illegal;
                    end
                endcase
            end
            ctrl_pkg::st_alu_add, ctrl_pkg::st_alu_and, ctrl_pkg::st_alu_sub: begin
                next_state = ctrl_pkg::st_ov_check_r;
            end
            ctrl_pkg::st_alu_imm_trap: next_state = ctrl_pkg::st_ov_check_i;
            // addiu wraps silently
            ctrl_pkg::st_alu_imm_wrap: next_state = ctrl_pkg::st_write_rt;
            ctrl_pkg::st_ov_check_r, ctrl_pkg::st_ov_check_i: begin
                if (ov) begin
                    next_state = ctrl_pkg::st_exc_wait;
                    next_cause = ctrl_pkg::cause_overflow;
                end else if (state == ctrl_pkg::st_ov_check_r) begin
                    next_state = ctrl_pkg::st_write_rd;
                end else begin
                    next_state = ctrl_pkg::st_write_rt;
                end
            end
            ctrl_pkg::st_exc_wait: begin
                if (wait_done) begin
                    next_state = ctrl_pkg::st_exc_vector;
                end
            end
            default: next_state = ctrl_pkg::st_fetch_wait;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ctrl_pkg::st_stack_init;
            cause    <= ctrl_pkg::cause_illegal;
            wait_cnt <= '0;
        end else begin
            state    <= next_state;
            cause    <= next_cause;
            wait_cnt <= (in_wait && !wait_done) ? wait_cnt + 1'b1 : '0;
        end
    end

endmodule

`default_nettype wire

//--- control_unit.f
isa_pkg.sv
ctrl_pkg.sv
instr_decoder.sv
control_sequencer.sv
control_word_gen.sv
control_unit.sv
control_unit_tb.sv

//--- control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit #(
    parameter int MEM_WAIT = 2,
    parameter int EXC_WAIT = 8
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire isa_pkg::opcode_e opcode,
    input  wire isa_pkg::funct_e  funct,
    input  wire                   ov,
    output ctrl_pkg::ctrl_word_t  ctrl
);

    isa_pkg::instr_class_e instr_class;
    ctrl_pkg::state_e      state;
    ctrl_pkg::exc_cause_e  cause;

    instr_decoder u_decoder (
        .opcode      (opcode),
        .funct       (funct),
        .instr_class (instr_class)
    );

    control_sequencer #(
        .MEM_WAIT (MEM_WAIT),
        .EXC_WAIT (EXC_WAIT)
    ) u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .ov          (ov),
        .state       (state),
        .cause       (cause)
    );

    control_word_gen u_word_gen (
        .state (state),
        .cause (cause),
        .ctrl  (ctrl)
    );

endmodule

`default_nettype wire

//--- control_unit_golden.txt
# opcode funct ov outcome; opcode, funct and ov in hex
# outcome: 0 write rd, 1 write rt, 2 overflow, 3 illegal
00 20 0 0
00 24 0 0
00 22 0 0
00 20 1 2
00 22 1 2
08 00 0 1
08 3f 1 2
09 00 1 1
09 11 0 1
23 00 0 3
04 00 0 3
00 00 0 3
00 08 1 3
2b 20 1 3
00 18 0 3
0f 00 0 3

//--- control_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit_tb;

    localparam int MEM_WAIT   = 2;
    localparam int EXC_WAIT   = 8;
    localparam int CLK_PERIOD = 20;
    localparam int MAX_VEC    = 64;

    logic                 clk;
    logic                 reset;
    isa_pkg::opcode_e     opcode;
    isa_pkg::funct_e      funct;
    logic                 ov;
    ctrl_pkg::ctrl_word_t ctrl;

    logic [5:0]  vec_op [MAX_VEC];
    logic [5:0]  vec_fn [MAX_VEC];
    logic        vec_ov [MAX_VEC];
    int          vec_out [MAX_VEC];
    int          num_vec;
    bit          loaded;
    int          errors;
    logic [31:0] lcg_state;

    control_unit #(
        .MEM_WAIT (MEM_WAIT),
        .EXC_WAIT (EXC_WAIT)
    ) uut (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .ov     (ov),
        .ctrl   (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Two instruction slots per golden line is ample
    initial begin
        wait (loaded);
        #((2 * num_vec * (MEM_WAIT + EXC_WAIT + 8) + 5) * CLK_PERIOD);
        $display("Watchdog expired before all instructions were checked");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input bit ok, input string msg);
        assert (ok) else begin
            errors++;
            $display("Mismatch at %0t: %s", $time, msg);
        end
    endtask

    // Opcode and funct are don't-care here
    task automatic drive_filler();
        lcg_state = lcg_next(lcg_state);
        opcode    = isa_pkg::opcode_e'(lcg_state[31:26]);
        funct     = isa_pkg::funct_e'(lcg_state[21:16]);
        ov        = lcg_state[15];
    endtask

    task automatic load_golden();
        int         fd;
        int         n;
        string      line;
        logic [5:0] op;
        logic [5:0] fn;
        logic       o;
        int         outc;
        num_vec = 0;
        fd = $fopen("control_unit_golden.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("Could not open control_unit_golden.txt");
        end
        while (fd != 0 && !$feof(fd) && num_vec < MAX_VEC) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%h %h %h %d", op, fn, o, outc) == 4) begin
                vec_op[num_vec]  = op;
                vec_fn[num_vec]  = fn;
                vec_ov[num_vec]  = o;
                vec_out[num_vec] = outc;
                num_vec++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        assert (num_vec > 0) else begin
            errors++;
            $display("The golden file holds no test instructions");
        end
    endtask

    task automatic run_instruction(input int v);
        int                   cyc;
        int                   alu_cyc;
        int                   exc_cyc;
        int                   exc_len;
        int                   exp_end;
        bit                   done;
        ctrl_pkg::ctrl_word_t alu_word;
        ctrl_pkg::ctrl_word_t end_word;
        ctrl_pkg::exc_cause_e seen_cause;
        ctrl_pkg::alu_op_e    exp_alu;
        cyc  = 0;
        done = 1'b0;
        while (!done && cyc < MEM_WAIT + 4) begin
            @(negedge clk);
            cyc++;
            done = ctrl.wr.ir_write;
            if (!done) begin
                check_value(!ctrl.wr.pc_write, "pc_write high during fetch wait");
                drive_filler();
            end
        end
        assert (done) else begin
            errors++;
            $display("No ir_write pulse seen for instruction %0d", v);
        end
        if (!done) begin
            return;
        end
        check_value(cyc == MEM_WAIT + 1, $sformatf("ir_write after %0d cycles", cyc));
        check_value(ctrl.wr.pc_write && ctrl.wr.mem_wr, "pc_write or mem_wr low in fetch latch");
        // Held from decode until the instruction ends
        opcode     = isa_pkg::opcode_e'(vec_op[v]);
        funct      = isa_pkg::funct_e'(vec_fn[v]);
        ov         = vec_ov[v];
        cyc        = 0;
        alu_cyc    = -1;
        exc_cyc    = -1;
        exc_len    = 0;
        done       = 1'b0;
        alu_word   = '0;
        seen_cause = ctrl_pkg::cause_illegal;
        while (!done && cyc < EXC_WAIT + 8) begin
            @(negedge clk);
            cyc++;
            if (ctrl.wr.alu_out_write && alu_cyc < 0) begin
                alu_cyc  = cyc;
                alu_word = ctrl;
            end
            if (ctrl.sel.addr_src == ctrl_pkg::addr_vector) begin
                if (exc_cyc < 0) begin
                    exc_cyc    = cyc;
                    seen_cause = ctrl.sel.except_cause;
                end
                exc_len++;
            end
            done = ctrl.wr.reg_write || ctrl.wr.epc_write;
        end
        end_word = ctrl;
        assert (done) else begin
            errors++;
            $display("Instruction %0d never wrote a register or the EPC", v);
        end
        if (vec_out[v] < 2) begin
            exp_alu = ctrl_pkg::alu_add;
            if (vec_out[v] == 0 && vec_fn[v] == 6'h24) begin
                exp_alu = ctrl_pkg::alu_and;
            end else if (vec_out[v] == 0 && vec_fn[v] == 6'h22) begin
                exp_alu = ctrl_pkg::alu_sub;
            end
            // addiu skips the overflow check state
            exp_end = (vec_out[v] == 1 && vec_op[v] == 6'h09) ? 4 : 5;
            check_value(alu_cyc == 3 && alu_word.sel.alu_op == exp_alu,
                        $sformatf("instruction %0d ALU step wrong", v));
            check_value(alu_word.sel.alu_src_a == ctrl_pkg::src_a_reg_a &&
                        alu_word.sel.alu_src_b == ((vec_out[v] == 0) ? ctrl_pkg::src_b_reg_b
                                                                     : ctrl_pkg::src_b_imm),
                        $sformatf("instruction %0d ALU sources wrong", v));
            check_value(end_word.wr.reg_write && !end_word.wr.epc_write && exc_cyc < 0 &&
                        end_word.sel.reg_dst == ((vec_out[v] == 0) ? ctrl_pkg::dst_rd
                                                                   : ctrl_pkg::dst_rt),
                        $sformatf("instruction %0d write-back wrong", v));
        end else begin
            exp_end = ((vec_out[v] == 2) ? 5 : 3) + EXC_WAIT;
            check_value(exc_cyc == exp_end - EXC_WAIT && exc_len == EXC_WAIT,
                        $sformatf("instruction %0d exception entry at %0d for %0d cycles",
                                  v, exc_cyc, exc_len));
            check_value(seen_cause == ((vec_out[v] == 2) ? ctrl_pkg::cause_overflow
                                                         : ctrl_pkg::cause_illegal),
                        $sformatf("instruction %0d exception cause wrong", v));
            check_value(end_word.wr.epc_write && end_word.wr.pc_write &&
                        !end_word.wr.reg_write && end_word.sel.pc_src == ctrl_pkg::pc_vector,
                        $sformatf("instruction %0d vector step wrong", v));
        end
        check_value(cyc == exp_end, $sformatf("instruction %0d ended after %0d cycles", v, cyc));
    endtask

    initial begin
        ctrl_pkg::ctrl_write_t exp_wr;
        reset     = 1'b1;
        opcode    = isa_pkg::op_rtype;
        funct     = isa_pkg::fn_add;
        ov        = 1'b0;
        errors    = 0;
        loaded    = 1'b0;
        lcg_state = 32'h7d71_74fc;
        exp_wr    = '0;
        exp_wr.reg_write = 1'b1;
        load_golden();
        loaded = 1'b1;
        @(posedge clk);
        // Stack init word is shown all through reset
        repeat (5) begin
            @(negedge clk);
            check_value(ctrl.wr == exp_wr && ctrl.sel.reg_dst == ctrl_pkg::dst_stack &&
                        ctrl.sel.reg_src == ctrl_pkg::wb_stack_top, "stack init word wrong");
        end
        reset = 1'b0;
        for (int v = 0; v < num_vec; v++) begin
            run_instruction(v);
        end
        $display("Checked %0d instructions with %0d errors", num_vec, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- control_word_gen.sv
`timescale 1ns/1ps
`default_nettype none

module control_word_gen (
    input  wire ctrl_pkg::state_e     state,
    input  wire ctrl_pkg::exc_cause_e cause,
    output ctrl_pkg::ctrl_word_t      ctrl
);

    always_comb begin
        ctrl = '0;
        case (state)
            ctrl_pkg::st_stack_init: begin
                ctrl.wr.reg_write   = 1'b1;
                ctrl.sel.reg_dst    = ctrl_pkg::dst_stack;
                ctrl.sel.reg_src    = ctrl_pkg::wb_stack_top;
            end
            ctrl_pkg::st_fetch_wait: begin
                ctrl.sel.addr_src   = ctrl_pkg::addr_pc;
                ctrl.sel.alu_src_a  = ctrl_pkg::src_a_pc;
                ctrl.sel.alu_src_b  = ctrl_pkg::src_b_four;
                ctrl.sel.alu_op     = ctrl_pkg::alu_add;
            end
            // PC <= PC + 4 while the instruction is latched
            ctrl_pkg::st_fetch_latch: begin
                ctrl.wr.pc_write    = 1'b1;
                ctrl.wr.ir_write    = 1'b1;
                ctrl.wr.mem_wr      = 1'b1;
                ctrl.sel.addr_src   = ctrl_pkg::addr_pc_hold;
                ctrl.sel.alu_src_a  = ctrl_pkg::src_a_pc;
                ctrl.sel.alu_src_b  = ctrl_pkg::src_b_four;
                ctrl.sel.alu_op     = ctrl_pkg::alu_add;
                ctrl.sel.pc_src     = ctrl_pkg::pc_alu;
            end
            ctrl_pkg::st_decode_regs, ctrl_pkg::st_dispatch: begin
                ctrl.wr.a_write     = (state == ctrl_pkg::st_decode_regs);
                ctrl.wr.b_write     = (state == ctrl_pkg::st_decode_regs);
                ctrl.sel.addr_src   = ctrl_pkg::addr_pc_hold;
                ctrl.sel.alu_src_a  = ctrl_pkg::src_a_pc;
                ctrl.sel.alu_src_b  = ctrl_pkg::src_b_four;
                ctrl.sel.alu_op     = ctrl_pkg::alu_add;
            end
            ctrl_pkg::st_alu_add, ctrl_pkg::st_alu_and, ctrl_pkg::st_alu_sub: begin
                ctrl.wr.alu_out_write = 1'b1;
                ctrl.sel.alu_src_a  = ctrl_pkg::src_a_reg_a;
                ctrl.sel.alu_src_b  = ctrl_pkg::src_b_reg_b;
                if (state == ctrl_pkg::st_alu_and) begin
                    ctrl.sel.alu_op = ctrl_pkg::alu_and;
                end else if (state == ctrl_pkg::st_alu_sub) begin
                    ctrl.sel.alu_op = ctrl_pkg::alu_sub;
                end else begin
                    ctrl.sel.alu_op = ctrl_pkg::alu_add;
                end
            end
            // Same datapath op for addi and addiu, only the trap differs
            ctrl_pkg::st_alu_imm_trap, ctrl_pkg::st_alu_imm_wrap: begin
                ctrl.wr.alu_out_write = 1'b1;
                ctrl.sel.alu_src_a  = ctrl_pkg::src_a_reg_a;
                ctrl.sel.alu_src_b  = ctrl_pkg::src_b_imm;
                ctrl.sel.alu_op     = ctrl_pkg::alu_add;
            end
            ctrl_pkg::st_write_rd, ctrl_pkg::st_write_rt: begin
                ctrl.wr.reg_write   = 1'b1;
                ctrl.sel.reg_src    = ctrl_pkg::wb_alu_out;
                ctrl.sel.reg_dst    = (state == ctrl_pkg::st_write_rd) ? ctrl_pkg::dst_rd
                                                                      : ctrl_pkg::dst_rt;
            end
            ctrl_pkg::st_exc_wait: begin
                ctrl.sel.addr_src     = ctrl_pkg::addr_vector;
                ctrl.sel.except_cause = cause;
            end
            ctrl_pkg::st_exc_vector: begin
                ctrl.wr.epc_write   = 1'b1;
                ctrl.wr.pc_write    = 1'b1;
                ctrl.sel.pc_src     = ctrl_pkg::pc_vector;
            end
            // Overflow check states drive no writes
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [3:0] {
        st_stack_init,
        st_fetch_wait,
        st_fetch_latch,
        st_decode_regs,
        st_dispatch,
        st_alu_add,
        st_alu_and,
        st_alu_sub,
        st_alu_imm_trap,
        st_alu_imm_wrap,
        st_ov_check_r,
        st_ov_check_i,
        st_write_rd,
        st_write_rt,
        st_exc_wait,
        st_exc_vector
    } state_e;

    typedef enum logic [1:0] {cause_illegal = 2'd0, cause_overflow = 2'd1} exc_cause_e;

    typedef enum logic [2:0] {alu_pass = 3'd0, alu_add = 3'd1, alu_and = 3'd2, alu_sub = 3'd3} alu_op_e;

    typedef enum logic [1:0] {src_a_pc = 2'd0, src_a_reg_a = 2'd1} alu_src_a_e;
    typedef enum logic [2:0] {src_b_reg_b = 3'd0, src_b_four = 3'd1, src_b_imm = 3'd2} alu_src_b_e;

    // Memory address mux
    typedef enum logic [2:0] {addr_pc = 3'd0, addr_pc_hold = 3'd1, addr_vector = 3'd2} addr_src_e;
    typedef enum logic [2:0] {pc_alu = 3'd0, pc_vector = 3'd3} pc_src_e;

    typedef enum logic [1:0] {dst_rt = 2'd0, dst_rd = 2'd1, dst_stack = 2'd2} reg_dst_e;
    // Register file write-back source
    typedef enum logic [3:0] {wb_alu_out = 4'd0, wb_stack_top = 4'd4} reg_src_e;

    typedef struct packed {
        logic pc_write;
        logic ir_write;
        logic a_write;
        logic b_write;
        logic alu_out_write;
        logic epc_write;
        logic reg_write;
        logic mem_wr;
    } ctrl_write_t;

    typedef struct packed {
        alu_src_a_e alu_src_a;
        alu_src_b_e alu_src_b;
        alu_op_e    alu_op;
        addr_src_e  addr_src;
        pc_src_e    pc_src;
        reg_dst_e   reg_dst;
        reg_src_e   reg_src;
        exc_cause_e except_cause;
    } ctrl_select_t;

    typedef struct packed {
        ctrl_write_t  wr;
        ctrl_select_t sel;
    } ctrl_word_t;

endpackage

`default_nettype wire

//--- instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire isa_pkg::opcode_e      opcode,
    input  wire isa_pkg::funct_e       funct,
    output isa_pkg::instr_class_e      instr_class
);

    always_comb begin
        instr_class = isa_pkg::cls_illegal;
        case (opcode)
            isa_pkg::op_rtype: begin
                // Shifts, mult/div, jr and friends fall through to illegal
                case (funct)
                    isa_pkg::fn_add: instr_class = isa_pkg::cls_add;
                    isa_pkg::fn_and: instr_class = isa_pkg::cls_and;
                    isa_pkg::fn_sub: instr_class = isa_pkg::cls_sub;
                    default: begin
                        instr_class = isa_pkg::cls_illegal;
                    end
                endcase
            end
            isa_pkg::op_addi: begin
                instr_class = isa_pkg::cls_addi;
            end
            isa_pkg::op_addiu: begin
                instr_class = isa_pkg::cls_addiu;
            end
            // Loads, stores, branches, jumps
            default: begin
                instr_class = isa_pkg::cls_illegal;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_addiu = 6'h09
    } opcode_e;

    // R-form function field, instr[5:0]
    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24
    } funct_e;

    // Supported instructions after decode
    typedef enum logic [2:0] {
        cls_add,
        cls_and,
        cls_sub,
        cls_addi,
        cls_addiu,
        cls_illegal
    } instr_class_e;

endpackage

`default_nettype wire
